/* src/dcache_settings.svh */
// address split, line count and memory credit limit for the data cache
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width
`define DC_ADDR_W 32

// byte offset inside one line
`define DC_OFFSET_W 4

// line index, 64 lines
`define DC_INDEX_W 6
`define DC_LINES (1 << `DC_INDEX_W)

// whatever is left above index and offset
`define DC_TAG_W 22

`define DC_LINE_W 128

// outstanding memory requests allowed
`define DC_MEM_CREDITS 2

`endif

/* src/dcache_pkg.sv */
// controller state type and cache line union for the data cache
`include "dcache_settings.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,     // read hit, data next cycle
        st_store,       // write hit merge
        st_writeback,   // dirty victim out
        st_fill_req,
        st_fill_wait,
        st_fence_walk
    } cache_state_e;

    // one line seen two ways
    // raw for memory transfers, dw for cpu doubleword access (addr bit 3)
    typedef union packed {
        logic [`DC_LINE_W-1:0] raw;
        logic [1:0][`DC_LINE_W/2-1:0] dw;
    } cache_line_u;

endpackage

/* src/dcache_ctrl_fsm.sv */
// data cache controller FSM for lookup, fill, writeback, store and fence
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl_fsm (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_req_valid_i,
    input  logic                   cpu_we_i,
    input  logic                   cpu_fence_i,
    input  logic [`DC_INDEX_W-1:0] cpu_index_i,
    input  logic [`DC_TAG_W-1:0]   cpu_tag_i,
    input  logic                   hit_i,
    input  logic                   victim_dirty_i,
    input  logic                   victim_valid_i,
    input  logic [`DC_TAG_W-1:0]   victim_tag_i,
    input  logic                   fill_valid_i,
    input  logic                   can_issue_i,
    input  logic                   flush_last_i,
    input  logic [`DC_INDEX_W-1:0] flush_index_i,
    output logic                   cpu_ready_o,
    output logic                   cpu_idle_o,
    output logic [`DC_INDEX_W-1:0] line_index_o,
    output logic                   tag_we_o,
    output logic                   dirty_set_o,
    output logic                   dirty_clr_o,
    output logic                   ram_we_o,
    output logic                   ram_fill_sel_o,
    output logic                   issue_o,
    output logic                   issue_we_o,
    output logic [`DC_ADDR_W-1:0]  issue_addr_o,
    output logic                   flush_step_o,
    output logic                   flush_clear_o
);

    dcache_pkg::cache_state_e state_q, state_d;
    logic use_flush_index;
    logic victim_wb;
    logic rd_ok_q; // ram output matches the walker index

    assign use_flush_index = (state_q == dcache_pkg::st_fence_walk);
    assign line_index_o = use_flush_index ? flush_index_i : cpu_index_i;
    assign victim_wb = victim_valid_i && victim_dirty_i;
    assign cpu_idle_o = (state_q == dcache_pkg::st_idle);

    // writes carry the victim tag, fills the cpu tag
    assign issue_we_o = (state_q == dcache_pkg::st_writeback) || use_flush_index;
    assign issue_addr_o = {issue_we_o ? victim_tag_i : cpu_tag_i, line_index_o,
                           {`DC_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::st_idle;
            cpu_ready_o <= 1'b0;
            rd_ok_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cpu_ready_o <= (state_q == dcache_pkg::st_respond) ||
                           (state_q == dcache_pkg::st_store);
            rd_ok_q <= use_flush_index && !flush_step_o;
        end
    end

    always_comb begin
        state_d = state_q;
        tag_we_o = 1'b0;
        dirty_set_o = 1'b0;
        dirty_clr_o = 1'b0;
        ram_we_o = 1'b0;
        ram_fill_sel_o = 1'b0;
        issue_o = 1'b0;
        flush_step_o = 1'b0;
        flush_clear_o = 1'b0;
        case (state_q)
            dcache_pkg::st_idle: begin
                if (cpu_fence_i) begin // fence wins over a request
                    flush_clear_o = 1'b1;
                    state_d = dcache_pkg::st_fence_walk;
                end else if (cpu_req_valid_i && !cpu_ready_o) begin
                    state_d = dcache_pkg::st_lookup;
                end
            end
            dcache_pkg::st_lookup: begin
                if (hit_i) begin
                    state_d = cpu_we_i ? dcache_pkg::st_store : dcache_pkg::st_respond;
                end else if (victim_wb) begin
                    state_d = dcache_pkg::st_writeback;
                end else begin
                    state_d = dcache_pkg::st_fill_req;
                end
            end
            dcache_pkg::st_respond: state_d = dcache_pkg::st_idle;
            dcache_pkg::st_store: begin
                ram_we_o = 1'b1;
                dirty_set_o = 1'b1;
                state_d = dcache_pkg::st_idle;
            end
            dcache_pkg::st_writeback: begin
                if (can_issue_i) begin
                    issue_o = 1'b1;
                    dirty_clr_o = 1'b1;
                    state_d = dcache_pkg::st_fill_req;
                end
            end
            dcache_pkg::st_fill_req: begin
                if (can_issue_i) begin
                    issue_o = 1'b1;
                    state_d = dcache_pkg::st_fill_wait;
                end
            end
            dcache_pkg::st_fill_wait: begin
                if (fill_valid_i) begin
                    ram_we_o = 1'b1;
                    ram_fill_sel_o = 1'b1;
                    tag_we_o = 1'b1;
                    state_d = dcache_pkg::st_lookup; // replay, now a hit
                end
            end
            dcache_pkg::st_fence_walk: begin
                // dirty lines wait for ram data and a credit, clean ones are skipped
                if (!victim_wb || (rd_ok_q && can_issue_i)) begin
                    issue_o = victim_wb;
                    dirty_clr_o = victim_wb;
                    if (flush_last_i) begin
                        state_d = dcache_pkg::st_idle;
                    end else begin
                        flush_step_o = 1'b1;
                    end
                end
            end
            default: state_d = dcache_pkg::st_idle;
        endcase
    end

endmodule

/* src/flush_index_counter.sv */
// line index walker for fence with a last-index flag
`timescale 1ns/1ps
`include "dcache_settings.svh"

module flush_index_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear_i,
    input  logic                   step_i,
    output logic [`DC_INDEX_W-1:0] index_o,
    output logic                   last_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            index_o <= '0;
        end else if (clear_i) begin
            index_o <= '0; // start of a new walk
        end else if (step_i) begin
            index_o <= index_o + 1'b1;
        end
    end

    assign last_o = (index_o == `DC_INDEX_W'(`DC_LINES - 1));

endmodule

/* src/tag_store.sv */
// valid, dirty and tag arrays with hit and victim lookup
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tag_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] index_i,
    input  logic [`DC_TAG_W-1:0]   tag_i,
    input  logic                   tag_we_i,
    input  logic                   dirty_set_i,
    input  logic                   dirty_clr_i,
    output logic                   hit_o,
    output logic                   victim_valid_o,
    output logic                   victim_dirty_o,
    output logic [`DC_TAG_W-1:0]   victim_tag_o
);

    logic [`DC_LINES-1:0] valid_q;
    logic [`DC_LINES-1:0] dirty_q;
    logic [`DC_TAG_W-1:0] tag_q [`DC_LINES];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (tag_we_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0; // fresh line from memory
            end else if (dirty_set_i) begin
                dirty_q[index_i] <= 1'b1;
            end else if (dirty_clr_i) begin
                dirty_q[index_i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_q[index_i] <= tag_i;
        end
    end

    // combinational lookup at the current index
    assign victim_valid_o = valid_q[index_i];
    assign victim_dirty_o = dirty_q[index_i];
    assign victim_tag_o = tag_q[index_i];
    assign hit_o = valid_q[index_i] && (tag_q[index_i] == tag_i);

endmodule

/* src/line_ram.sv */
// line data array with registered read and byte-masked store merge
`timescale 1ns/1ps
`include "dcache_settings.svh"

module line_ram (
    input  logic                     clk,
    input  logic [`DC_INDEX_W-1:0]   index_i,
    input  logic                     we_i,
    input  logic                     fill_sel_i,
    input  dcache_pkg::cache_line_u  fill_data_i,
    input  logic [63:0]              store_data_i,
    input  logic [7:0]               store_mask_i,
    input  logic                     dword_sel_i,
    output dcache_pkg::cache_line_u  rdata_o,
    output logic [63:0]              dword_o
);

    dcache_pkg::cache_line_u mem_q [`DC_LINES];
    dcache_pkg::cache_line_u merged;

    // store bytes go into the line read on the previous cycle
    always_comb begin
        merged = rdata_o;
        for (int b = 0; b < 8; b++) begin
            if (store_mask_i[b]) begin
                merged.dw[dword_sel_i][8*b +: 8] = store_data_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[index_i] <= fill_sel_i ? fill_data_i : merged;
        end
        rdata_o <= mem_q[index_i]; // old data on a same-cycle write
    end

    assign dword_o = rdata_o.dw[dword_sel_i];

endmodule

/* src/mem_credit_port.sv */
// memory request register, credit counter and fill forwarding
`timescale 1ns/1ps
`include "dcache_settings.svh"

module mem_credit_port (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_i,
    input  logic                     issue_we_i,
    input  logic [`DC_ADDR_W-1:0]    issue_addr_i,
    input  dcache_pkg::cache_line_u  issue_data_i,
    input  logic                     mem_credit_i,
    input  logic                     mem_rvalid_i,
    input  logic [`DC_LINE_W-1:0]    mem_rdata_i,
    output logic                     can_issue_o,
    output logic                     mem_req_valid_o,
    output logic                     mem_req_we_o,
    output logic [`DC_ADDR_W-1:0]    mem_req_addr_o,
    output logic [`DC_LINE_W-1:0]    mem_req_wdata_o,
    output logic                     fill_valid_o,
    output dcache_pkg::cache_line_u  fill_data_o
);

    localparam int CNT_W = $clog2(`DC_MEM_CREDITS + 1);

    logic [CNT_W-1:0] credit_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= CNT_W'(`DC_MEM_CREDITS);
            mem_req_valid_o <= 1'b0;
        end else begin
            mem_req_valid_o <= issue_i;
            // issue and return in one cycle cancel out
            case ({issue_i, mem_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            mem_req_we_o <= issue_we_i;
            mem_req_addr_o <= issue_addr_i;
            mem_req_wdata_o <= issue_data_i.raw;
        end
    end

    assign can_issue_o = (credit_q != '0);

    // read responses arrive in order, only the one fill is outstanding
    assign fill_valid_o = mem_rvalid_i;
    assign fill_data_o.raw = mem_rdata_i;

endmodule

/* src/dcache_top.sv */
// data cache top level with controller, walker, tag store, line ram and memory port
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req_valid_i,
    input  logic [`DC_ADDR_W-1:0] cpu_addr_i,
    input  logic                  cpu_we_i,
    input  logic [63:0]           cpu_wdata_i,
    input  logic [7:0]            cpu_wmask_i,
    input  logic                  cpu_fence_i,
    output logic [63:0]           cpu_rdata_o,
    output logic                  cpu_ready_o,
    output logic                  cpu_idle_o,
    output logic                  mem_req_valid_o,
    output logic                  mem_req_we_o,
    output logic [`DC_ADDR_W-1:0] mem_req_addr_o,
    output logic [`DC_LINE_W-1:0] mem_req_wdata_o,
    input  logic                  mem_credit_i,
    input  logic                  mem_rvalid_i,
    input  logic [`DC_LINE_W-1:0] mem_rdata_i
);

    logic [`DC_INDEX_W-1:0] line_index, flush_index;
    logic [`DC_TAG_W-1:0] victim_tag;
    logic [`DC_ADDR_W-1:0] issue_addr;
    logic hit, victim_valid, victim_dirty;
    logic tag_we, dirty_set, dirty_clr, ram_we, ram_fill_sel;
    logic issue, issue_we, can_issue, fill_valid;
    logic flush_step, flush_clear, flush_last;
    dcache_pkg::cache_line_u ram_rdata;
    dcache_pkg::cache_line_u fill_data;

    dcache_ctrl_fsm u_ctrl (
        .clk(clk), .rst(rst),
        .cpu_req_valid_i(cpu_req_valid_i), .cpu_we_i(cpu_we_i), .cpu_fence_i(cpu_fence_i),
        .cpu_index_i(cpu_addr_i[`DC_OFFSET_W +: `DC_INDEX_W]),
        .cpu_tag_i(cpu_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W]),
        .hit_i(hit), .victim_dirty_i(victim_dirty), .victim_valid_i(victim_valid),
        .victim_tag_i(victim_tag), .fill_valid_i(fill_valid), .can_issue_i(can_issue),
        .flush_last_i(flush_last), .flush_index_i(flush_index),
        .cpu_ready_o(cpu_ready_o), .cpu_idle_o(cpu_idle_o), .line_index_o(line_index),
        .tag_we_o(tag_we), .dirty_set_o(dirty_set), .dirty_clr_o(dirty_clr),
        .ram_we_o(ram_we), .ram_fill_sel_o(ram_fill_sel),
        .issue_o(issue), .issue_we_o(issue_we), .issue_addr_o(issue_addr),
        .flush_step_o(flush_step), .flush_clear_o(flush_clear)
    );

    flush_index_counter u_flush (
        .clk(clk), .rst(rst), .clear_i(flush_clear), .step_i(flush_step),
        .index_o(flush_index), .last_o(flush_last)
    );

    tag_store u_tags (
        .clk(clk), .rst(rst), .index_i(line_index),
        .tag_i(cpu_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W]),
        .tag_we_i(tag_we), .dirty_set_i(dirty_set), .dirty_clr_i(dirty_clr),
        .hit_o(hit), .victim_valid_o(victim_valid), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag)
    );

    line_ram u_ram (
        .clk(clk), .index_i(line_index), .we_i(ram_we), .fill_sel_i(ram_fill_sel),
        .fill_data_i(fill_data), .store_data_i(cpu_wdata_i), .store_mask_i(cpu_wmask_i),
        .dword_sel_i(cpu_addr_i[`DC_OFFSET_W-1]), // addr bit 3
        .rdata_o(ram_rdata), .dword_o(cpu_rdata_o)
    );

    mem_credit_port u_mem (
        .clk(clk), .rst(rst), .issue_i(issue), .issue_we_i(issue_we),
        .issue_addr_i(issue_addr), .issue_data_i(ram_rdata),
        .mem_credit_i(mem_credit_i), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
        .can_issue_o(can_issue), .mem_req_valid_o(mem_req_valid_o),
        .mem_req_we_o(mem_req_we_o), .mem_req_addr_o(mem_req_addr_o),
        .mem_req_wdata_o(mem_req_wdata_o), .fill_valid_o(fill_valid), .fill_data_o(fill_data)
    );

endmodule

/* testbench/dcache_chk.sv */
// credit, reset and handshake assertions for the data cache, bound into dcache_top
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     cpu_ready_i,
    input logic                     cpu_idle_i,
    input logic                     mem_req_valid_i,
    input logic                     mem_credit_i,
    input dcache_pkg::cache_state_e state_i
);

    int outstanding; // sent, credit not back yet

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + (mem_req_valid_i ? 1 : 0) - (mem_credit_i ? 1 : 0);
        end
    end

    reset_values: assert property (@(posedge clk)
        rst |=> (!cpu_ready_i && !mem_req_valid_i && cpu_idle_i))
        else $error("outputs not at their reset values after reset");

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= `DC_MEM_CREDITS)
        else $error("more memory requests outstanding than credits");

    req_needs_credit: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_i |-> (outstanding < `DC_MEM_CREDITS))
        else $error("memory request sent with no credit left");

    // issuing states hold back while the port has no credit
    no_credit_stall: assert property (@(posedge clk) disable iff (rst)
        (state_i inside {dcache_pkg::st_writeback, dcache_pkg::st_fill_req,
            dcache_pkg::st_fence_walk} &&
         outstanding + (mem_req_valid_i ? 1 : 0) >= `DC_MEM_CREDITS) |=> !mem_req_valid_i)
        else $error("memory request issued during a stall with no credit");

    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_ready_i |=> !cpu_ready_i)
        else $error("cpu ready held longer than one cycle");

endmodule

bind dcache_top dcache_chk u_chk (
    .clk(clk),
    .rst(rst),
    .cpu_ready_i(cpu_ready_o),
    .cpu_idle_i(cpu_idle_o),
    .mem_req_valid_i(mem_req_valid_o),
    .mem_credit_i(mem_credit_i),
    .state_i(u_ctrl.state_q)
);

/* testbench/dcache_tb.sv */
// data cache testbench with memory model, reference model and checks
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tb;

    localparam logic [63:0] FILL_KEY = 64'h5a3c_96e1_0f78_d24b;
    localparam logic [`DC_ADDR_W-1:0] ADDR_A = 32'h0000_1010;
    localparam logic [`DC_ADDR_W-1:0] ADDR_F = 32'h0004_0000;

    logic clk, rst;
    logic cpu_req_valid_i, cpu_we_i, cpu_fence_i, cpu_ready_o, cpu_idle_o;
    logic [`DC_ADDR_W-1:0] cpu_addr_i, mem_req_addr_o;
    logic [63:0] cpu_wdata_i, cpu_rdata_o;
    logic [7:0] cpu_wmask_i;
    logic mem_req_valid_o, mem_req_we_o, mem_credit_i, mem_rvalid_i;
    logic [`DC_LINE_W-1:0] mem_req_wdata_o, mem_rdata_i;

    logic [63:0] mem_dw [logic [`DC_ADDR_W-1:0]];    // keyed by dword address
    logic [63:0] shadow_dw [logic [`DC_ADDR_W-1:0]]; // what the cpu stored
    logic pend_we [$];
    logic [`DC_ADDR_W-1:0] pend_addr [$];
    logic req_we_log [$];
    logic [`DC_ADDR_W-1:0] req_addr_log [$];
    logic model_valid [`DC_LINES];
    logic model_dirty [`DC_LINES];
    logic [`DC_ADDR_W-1:0] model_line [`DC_LINES];
    integer seed = 47;
    int head_wait, max_pend, write_cnt;

    dcache_top u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [63:0] init_dw(input logic [`DC_ADDR_W-1:0] a);
        return {~a, a} ^ FILL_KEY;
    endfunction

    function automatic logic [63:0] mem_read(input logic [`DC_ADDR_W-1:0] a);
        return mem_dw.exists(a) ? mem_dw[a] : init_dw(a);
    endfunction

    function automatic logic [63:0] shadow_read(input logic [`DC_ADDR_W-1:0] a);
        return shadow_dw.exists(a) ? shadow_dw[a] : init_dw(a);
    endfunction

    function automatic logic [`DC_LINE_W-1:0] shadow_line(input logic [`DC_ADDR_W-1:0] a);
        dcache_pkg::cache_line_u ln;
        ln.dw[0] = shadow_read(a);
        ln.dw[1] = shadow_read(a + 8);
        return ln.raw;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string sig, input logic [127:0] exp,
                                   input logic [127:0] got);
        stop_run($sformatf("CHECK FAILED at %0t: %s expected %0h got %0h", $time, sig, exp, got));
    endtask

    // in-order memory, one head timer, credit and read data together
    always @(posedge clk) begin
        dcache_pkg::cache_line_u ln;
        logic [`DC_INDEX_W-1:0] idx;
        mem_credit_i <= 1'b0;
        mem_rvalid_i <= 1'b0;
        if (!rst) begin
            if (pend_we.size() > 0) begin
                head_wait = head_wait - 1;
                if (head_wait == 0) begin
                    if (!pend_we[0]) begin
                        ln.dw[0] = mem_read(pend_addr[0]);
                        ln.dw[1] = mem_read(pend_addr[0] + 8);
                        mem_rdata_i <= ln.raw;
                        mem_rvalid_i <= 1'b1;
                    end
                    mem_credit_i <= 1'b1;
                    void'(pend_we.pop_front());
                    void'(pend_addr.pop_front());
                    head_wait = 1 + ($unsigned($random(seed)) % 4);
                end
            end
            if (mem_req_valid_o) begin
                if (mem_req_we_o) begin
                    idx = mem_req_addr_o[`DC_OFFSET_W +: `DC_INDEX_W];
                    assert (model_dirty[idx] && model_line[idx] == mem_req_addr_o)
                        else stop_run("write request for a line that is not dirty in the cache");
                    assert (mem_req_wdata_o == shadow_line(mem_req_addr_o))
                        else report_mismatch("mem_req_wdata_o", shadow_line(mem_req_addr_o),
                                             mem_req_wdata_o);
                    ln.raw = mem_req_wdata_o;
                    mem_dw[mem_req_addr_o] = ln.dw[0];
                    mem_dw[mem_req_addr_o + 8] = ln.dw[1];
                    model_dirty[idx] = 1'b0;
                    write_cnt++;
                end
                if (pend_we.size() == 0) begin
                    head_wait = 1 + ($unsigned($random(seed)) % 4);
                end
                pend_we.push_back(mem_req_we_o);
                pend_addr.push_back(mem_req_addr_o);
                req_we_log.push_back(mem_req_we_o);
                req_addr_log.push_back(mem_req_addr_o);
                if (pend_we.size() > max_pend) max_pend = pend_we.size();
                assert (pend_we.size() <= `DC_MEM_CREDITS)
                    else stop_run("memory holds more requests than the credit limit");
            end
        end
    end

    task automatic cpu_access(input logic [`DC_ADDR_W-1:0] addr, input logic we,
                              input logic [63:0] wdata, input logic [7:0] wmask);
        logic [`DC_ADDR_W-1:0] line, dw_addr;
        logic [`DC_INDEX_W-1:0] idx;
        logic [63:0] exp;
        logic hit, wb;
        int n, base;
        line = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], `DC_OFFSET_W'(0)};
        dw_addr = {addr[`DC_ADDR_W-1:3], 3'b000};
        idx = addr[`DC_OFFSET_W +: `DC_INDEX_W];
        hit = model_valid[idx] && model_line[idx] == line;
        wb = !hit && model_valid[idx] && model_dirty[idx];
        base = req_we_log.size();
        @(posedge clk);
        cpu_req_valid_i <= 1'b1;
        cpu_addr_i <= addr;
        cpu_we_i <= we;
        cpu_wdata_i <= wdata;
        cpu_wmask_i <= wmask;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 500) stop_run("timeout waiting for cpu_ready_o");
        end while (!cpu_ready_o);
        exp = shadow_read(dw_addr);
        if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (wmask[b]) exp[8*b +: 8] = wdata[8*b +: 8];
            end
            shadow_dw[dw_addr] = exp;
        end else begin
            assert (cpu_rdata_o == exp)
                else report_mismatch("cpu_rdata_o", 128'(exp), 128'(cpu_rdata_o));
        end
        if (hit) begin
            assert (n == 4) else report_mismatch("cpu_ready_o latency", 128'(3), 128'(n - 1));
            assert (req_we_log.size() == base) else stop_run("memory request during a hit");
        end else begin
            assert (req_we_log.size() == base + (wb ? 2 : 1))
                else stop_run("wrong number of memory requests for a miss");
            if (wb) begin
                assert (req_we_log[base] && req_addr_log[base] == model_line[idx])
                    else stop_run("miss did not write back the dirty victim first");
            end
            assert (!req_we_log[$] && req_addr_log[$] == line)
                else stop_run("miss did not fetch the requested line");
            model_valid[idx] = 1'b1;
            model_line[idx] = line;
        end
        if (we) model_dirty[idx] = 1'b1;
        @(posedge clk);
        cpu_req_valid_i <= 1'b0;
    endtask

    task automatic run_fence();
        int n, dirty_cnt, wr_base;
        dirty_cnt = 0;
        foreach (model_dirty[i]) begin
            if (model_dirty[i]) dirty_cnt++;
        end
        wr_base = write_cnt;
        max_pend = 0;
        @(posedge clk);
        cpu_fence_i <= 1'b1;
        @(posedge clk);
        cpu_fence_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 2000) stop_run("timeout waiting for cpu_idle_o after fence");
        end while (!cpu_idle_o);
        n = 0;
        while (pend_we.size() > 0) begin
            @(negedge clk);
            n++;
            if (n > 100) stop_run("timeout waiting for memory to drain after fence");
        end
        assert (write_cnt - wr_base == dirty_cnt)
            else report_mismatch("fence writeback count", 128'(dirty_cnt), 128'(write_cnt - wr_base));
        assert (max_pend == `DC_MEM_CREDITS) else stop_run("fence writebacks never overlapped");
        foreach (shadow_dw[a]) begin
            assert (mem_read(a) == shadow_dw[a])
                else report_mismatch("memory dword", 128'(shadow_dw[a]), 128'(mem_read(a)));
        end
    endtask

    initial begin
        rst = 1'b1;
        cpu_req_valid_i = 1'b0;
        cpu_we_i = 1'b0;
        cpu_fence_i = 1'b0;
        cpu_addr_i = '0;
        cpu_wdata_i = '0;
        cpu_wmask_i = '0;
        mem_credit_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        head_wait = 0;
        max_pend = 0;
        write_cnt = 0;
        foreach (model_valid[i]) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_line[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        cpu_access(ADDR_A, 1'b0, '0, '0); // miss, fetched from memory
        cpu_access(ADDR_A, 1'b0, '0, '0);
        cpu_access(ADDR_A + 8, 1'b0, '0, '0);
        cpu_access(ADDR_A + 8, 1'b1, 64'hdead_beef_0123_4567, 8'b0101_1010);
        cpu_access(ADDR_A + 8, 1'b0, '0, '0);
        // same index, other tag
        cpu_access(ADDR_A + 32'h400, 1'b0, '0, '0);
        cpu_access(ADDR_A + 8, 1'b0, '0, '0);
        for (int i = 0; i < 16; i++) begin
            cpu_access(ADDR_F + 32'(i * 16) + 32'((i % 2) * 8), 1'b1,
                       {32'(i), ~32'(i)} ^ 64'h0f1e_2d3c_4b5a_6978, 8'hff ^ 8'(1 << (i % 8)));
        end
        run_fence();
        cpu_access(ADDR_F + 32'h38, 1'b0, '0, '0); // clean hit after the fence
        cpu_access(ADDR_F + 32'h40, 1'b0, '0, '0);
        $display("Test passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+src
src/dcache_pkg.sv
src/dcache_ctrl_fsm.sv
src/flush_index_counter.sv
src/tag_store.sv
src/line_ram.sv
src/mem_credit_port.sv
src/dcache_top.sv
testbench/dcache_chk.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dcache_tb -f filelist.f -o dcache_sim || exit 1
./obj_dir/dcache_sim 2>&1 | tee /dev/stderr | grep -x "Test passed" > /dev/null \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
